// File: uart_consts.svh
// ~~~~~~~~~~~~~~~~~~~~
// Default UART timing, receive buffer size
// and host transmit credits
// ~~~~~~~~~~~~~~~~~~~~

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Clock cycles per serial symbol, even and at least 4
`define UART_CYCLES_PER_SYMBOL 8

// Entries in the receive FIFO
`define UART_RXBUF_DEPTH 4

// Credits the host holds after reset
// The transmitter keeps one byte pending behind the one it shifts
`define UART_TX_CREDITS 1

`endif

// File: uart_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// UART data types, FSM state encodings
// and the frame and status structs
// ~~~~~~~~~~~~~~~~~~~~

package uart_pkg;

  typedef logic [7:0] uart_byte_t;

  // Symbol index within a frame, 0 to 9
  typedef logic [3:0] bit_idx_t;

  typedef logic [2:0] credit_t;

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // Byte handed from the receiver to the receive FIFO
  typedef struct packed {
    uart_byte_t data;
    logic       valid;
  } rx_frame_t;

  typedef struct packed {
    logic frame_err;
    logic overrun;
  } uart_status_t;

endpackage

// File: uart_baud_timer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Symbol timer giving mid-bit and end-of-bit ticks
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module uart_baud_timer #(
  parameter int cycles_per_symbol = 8
) (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic restart_i,
  output logic half_tick_o,
  output logic bit_tick_o
);

  localparam int CntW = $clog2(cycles_per_symbol);

  typedef logic [CntW-1:0] cnt_t;

  localparam cnt_t LastCnt = cnt_t'(cycles_per_symbol - 1);
  localparam cnt_t HalfCnt = cnt_t'(cycles_per_symbol / 2 - 1);

  // Counts cycles since the last restart, modulo one symbol
  cnt_t cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (restart_i || bit_tick_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // N cycles after restart, then every N cycles
  assign bit_tick_o = (cnt_q == LastCnt);

  // N/2 cycles after restart
  assign half_tick_o = (cnt_q == HalfCnt);

endmodule

// File: uart_tx.sv
// ~~~~~~~~~~~~~~~~~~~~
// Transmit FSM with a one-byte pending slot
// and a 10-symbol shift register
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "uart_consts.svh"

module uart_tx import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  uart_byte_t tx_data_i,
  input  logic       tx_valid_i,
  output logic       tx_credit_o,

  input  logic       bit_tick_i,
  output logic       timer_restart_o,

  output logic       tx_o
);

  tx_state_e  state_q;
  bit_idx_t   idx_q;
  logic [9:0] shift_q;
  logic       tx_q;
  logic       credit_q;
  logic       pend_valid_q;
  uart_byte_t pend_data_q;
  uart_byte_t load_data;
  logic       load;

  // Credits the host should still hold, tracked for the protocol check only
  credit_t    host_credit_q;

  // A pending byte goes out before a new one from the host
  assign load      = (state_q == TX_IDLE) && (pend_valid_q || tx_valid_i);
  assign load_data = pend_valid_q ? pend_data_q : tx_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q       <= TX_IDLE;
      idx_q         <= '0;
      tx_q          <= 1'b1;
      credit_q      <= 1'b0;
      pend_valid_q  <= 1'b0;
      host_credit_q <= credit_t'(`UART_TX_CREDITS);
    end else begin
      credit_q      <= load;
      host_credit_q <= host_credit_q - credit_t'(tx_valid_i) + credit_t'(credit_q);
      if (load && pend_valid_q) begin
        pend_valid_q <= 1'b0;
      end else if (tx_valid_i && state_q == TX_SEND) begin
        pend_valid_q <= 1'b1;
      end
      unique case (state_q)
        TX_IDLE: begin
          if (load) begin
            state_q <= TX_SEND;
            idx_q   <= '0;
            // Start bit
            tx_q    <= 1'b0;
          end
        end
        TX_SEND: begin
          if (bit_tick_i) begin
            tx_q <= shift_q[1];
            if (idx_q == bit_idx_t'(9)) begin
              state_q <= TX_IDLE;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (tx_valid_i && state_q == TX_SEND) begin
      pend_data_q <= tx_data_i;
    end
    if (load) begin
      shift_q <= {1'b1, load_data, 1'b0};
    end else if (state_q == TX_SEND && bit_tick_i) begin
      // Fill with idle level so the stop bit and line idle follow
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

  assign timer_restart_o = load;
  assign tx_credit_o     = credit_q;
  assign tx_o            = tx_q;

  // Host must hold a credit for every byte it presents
  a_tx_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_valid_i |-> host_credit_q != '0);

  // Line stays at the idle level between frames
  a_tx_idle_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == TX_IDLE |-> tx_q);

endmodule

// File: uart_rx.sv
// ~~~~~~~~~~~~~~~~~~~~
// Receive FSM with input synchronizer,
// mid-bit sampling and stop bit check
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module uart_rx import uart_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      rx_i,

  input  logic      half_tick_i,
  input  logic      bit_tick_i,
  output logic      timer_restart_o,

  output rx_frame_t frame_o,
  output logic      frame_err_o
);

  rx_state_e  state_q;
  bit_idx_t   idx_q;
  logic [1:0] rx_sync_q;
  logic       rx_prev_q;
  uart_byte_t shift_q;
  logic       frame_valid_q;
  logic       frame_err_q;
  logic       rx_s;
  logic       fall;
  logic       start_ok;

  assign rx_s = rx_sync_q[1];

  // rx_prev_q comes out of reset low, so a line held low from reset
  // never looks like a start bit until it has been high once
  assign fall = rx_prev_q && !rx_s;

  assign start_ok = (state_q == RX_START) && half_tick_i && !rx_s;

  // Restart at the falling edge to find mid start bit,
  // then again there so each bit_tick lands mid data bit
  assign timer_restart_o = ((state_q == RX_IDLE) && fall) || start_ok;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q       <= RX_IDLE;
      idx_q         <= '0;
      rx_sync_q     <= 2'b00;
      rx_prev_q     <= 1'b0;
      frame_valid_q <= 1'b0;
      frame_err_q   <= 1'b0;
    end else begin
      rx_sync_q     <= {rx_sync_q[0], rx_i};
      rx_prev_q     <= rx_s;
      frame_valid_q <= 1'b0;
      frame_err_q   <= 1'b0;
      unique case (state_q)
        RX_IDLE: begin
          if (fall) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (start_ok) begin
            state_q <= RX_DATA;
            idx_q   <= '0;
          end else if (half_tick_i) begin
            // Line went back high before mid start bit
            state_q <= RX_IDLE;
          end
        end
        RX_DATA: begin
          if (bit_tick_i) begin
            idx_q <= idx_q + 1'b1;
            if (idx_q == bit_idx_t'(7)) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (bit_tick_i) begin
            state_q       <= RX_IDLE;
            frame_valid_q <= rx_s;
            frame_err_q   <= !rx_s;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data arrives LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && bit_tick_i) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign frame_o     = '{data: shift_q, valid: frame_valid_q};
  assign frame_err_o = frame_err_q;

  // Timer restarts at the falling edge, so the start check comes before any bit_tick
  a_rx_start_before_tick: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == RX_START |-> !bit_tick_i);

endmodule

// File: uart_rx_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Receive FIFO released against consumer credits
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "uart_consts.svh"

module uart_rx_buffer import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  rx_frame_t  frame_i,

  input  logic       rx_credit_i,
  output uart_byte_t rx_data_o,
  output logic       rx_valid_o,

  output logic       overrun_o
);

  localparam int Depth = `UART_RXBUF_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  localparam int CntW  = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  uart_byte_t mem_q [Depth];
  ptr_t       wr_ptr_q;
  ptr_t       rd_ptr_q;
  cnt_t       count_q;
  credit_t    credit_q;
  logic       overrun_q;
  logic       pop;
  logic       full;
  logic       push;

  assign full = (count_q == cnt_t'(Depth));
  assign pop  = (count_q != '0) && (credit_q != '0);

  // A full buffer still takes a byte when one leaves in the same cycle
  assign push = frame_i.valid && (!full || pop);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      credit_q  <= '0;
      overrun_q <= 1'b0;
    end else begin
      overrun_q <= frame_i.valid && !push;
      credit_q  <= credit_q + credit_t'(rx_credit_i) - credit_t'(pop);
      count_q   <= count_q + cnt_t'(push) - cnt_t'(pop);
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= frame_i.data;
    end
  end

  // One valid cycle per byte, no ready
  assign rx_valid_o = pop;
  assign rx_data_o  = mem_q[rd_ptr_q];
  assign overrun_o  = overrun_q;

  // Consumer never hands out more credits than there are slots
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= credit_t'(Depth));

endmodule

// File: uart_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// UART top level, 8N1 with credit flow control
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "uart_consts.svh"

module uart_core import uart_pkg::*; #(
  parameter int cycles_per_symbol = `UART_CYCLES_PER_SYMBOL
) (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  uart_byte_t   tx_data_i,
  input  logic         tx_valid_i,
  output logic         tx_credit_o,

  output logic         tx_o,
  input  logic         rx_i,

  output uart_byte_t   rx_data_o,
  output logic         rx_valid_o,
  input  logic         rx_credit_i,

  output uart_status_t status_o
);

  logic      tx_restart;
  logic      tx_bit_tick;
  logic      rx_restart;
  logic      rx_half_tick;
  logic      rx_bit_tick;
  rx_frame_t rx_frame;
  logic      frame_err;
  logic      overrun;

  uart_baud_timer #(
    .cycles_per_symbol(cycles_per_symbol)
  ) u_tx_timer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .restart_i  (tx_restart),
    // Transmitter only needs symbol ends
    .half_tick_o(),
    .bit_tick_o (tx_bit_tick)
  );

  uart_tx u_tx (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .tx_data_i      (tx_data_i),
    .tx_valid_i     (tx_valid_i),
    .tx_credit_o    (tx_credit_o),
    .bit_tick_i     (tx_bit_tick),
    .timer_restart_o(tx_restart),
    .tx_o           (tx_o)
  );

  uart_baud_timer #(
    .cycles_per_symbol(cycles_per_symbol)
  ) u_rx_timer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .restart_i  (rx_restart),
    .half_tick_o(rx_half_tick),
    .bit_tick_o (rx_bit_tick)
  );

  uart_rx u_rx (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rx_i           (rx_i),
    .half_tick_i    (rx_half_tick),
    .bit_tick_i     (rx_bit_tick),
    .timer_restart_o(rx_restart),
    .frame_o        (rx_frame),
    .frame_err_o    (frame_err)
  );

  uart_rx_buffer u_rx_buffer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .frame_i    (rx_frame),
    .rx_credit_i(rx_credit_i),
    .rx_data_o  (rx_data_o),
    .rx_valid_o (rx_valid_o),
    .overrun_o  (overrun)
  );

  assign status_o = '{frame_err: frame_err, overrun: overrun};

endmodule

// File: tb_uart_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench checker that decodes tx_o, compares
// received bytes, status pulses and transmit credits
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_uart_checker import uart_pkg::*; #(
  parameter int cycles_per_symbol = 8
) (
  input  logic         clk_i,
  input  logic         rst_ni,

  // DUT outputs
  input  logic         tx_i,
  input  logic         tx_credit_i,
  input  uart_byte_t   rx_data_i,
  input  logic         rx_valid_i,
  input  uart_status_t status_i,

  // Expectations from the testbench top, driven on the rising edge
  input  logic [63:0]  test_name_i,
  input  logic         exp_tx_push_i,
  input  uart_byte_t   exp_tx_byte_i,
  input  logic         exp_rx_push_i,
  input  uart_byte_t   exp_rx_byte_i,
  input  logic         test_done_i,
  input  uart_status_t exp_status_i,

  output logic         idle_o,
  output int           passed_o,
  output int           failed_o
);

  localparam int Half = cycles_per_symbol / 2;

  uart_byte_t exp_tx_q [$];
  uart_byte_t exp_rx_q [$];
  uart_byte_t tx_shift;
  uart_byte_t exp_byte;
  logic       tx_prev;
  int         tx_cnt;
  int         sym;
  int         errs;
  int         ferr_cnt;
  int         ovr_cnt;
  int         credit_cnt;
  int         exp_credits;

  // Everything is sampled on the falling edge, half a cycle after the DUT updates
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      tx_cnt      = -1;
      tx_prev     = 1'b1;
      errs        = 0;
      ferr_cnt    = 0;
      ovr_cnt     = 0;
      credit_cnt  = 0;
      exp_credits = 0;
      passed_o    = 0;
      failed_o    = 0;
      idle_o      = 1'b1;
    end else begin
      if (exp_tx_push_i) begin
        exp_tx_q.push_back(exp_tx_byte_i);
        // One tx_credit_o pulse is owed for every byte the host sends
        exp_credits++;
      end
      if (exp_rx_push_i) begin
        exp_rx_q.push_back(exp_rx_byte_i);
      end

      // tx_o decoder, counting cycles from the first low sample of a start bit
      if (tx_cnt < 0) begin
        if (tx_prev && !tx_i) begin
          tx_cnt = 0;
        end
      end else begin
        tx_cnt++;
      end
      tx_prev = tx_i;
      if (tx_cnt >= Half && (tx_cnt - Half) % cycles_per_symbol == 0) begin
        sym = (tx_cnt - Half) / cycles_per_symbol;
        if (sym == 0) begin
          if (tx_i) begin
            $display("test %0s: start bit on tx_o did not last to mid-bit", test_name_i);
            errs++;
            tx_cnt = -1;
          end
        end else if (sym <= 8) begin
          tx_shift = {tx_i, tx_shift[7:1]};
        end else begin
          if (!tx_i) begin
            $display("ERROR %0s: tx_o stop bit expected 1 actual %b", test_name_i, tx_i);
            errs++;
          end
          if (exp_tx_q.size() == 0) begin
            $display("test %0s: unexpected frame %h on tx_o", test_name_i, tx_shift);
            errs++;
          end else begin
            exp_byte = exp_tx_q.pop_front();
            if (exp_byte != tx_shift) begin
              $display("ERROR %0s: tx_o byte expected %h actual %h",
                       test_name_i, exp_byte, tx_shift);
              errs++;
            end
          end
          tx_cnt = -1;
        end
      end

      if (rx_valid_i) begin
        if (exp_rx_q.size() == 0) begin
          $display("test %0s: unexpected byte %h on rx_data_o", test_name_i, rx_data_i);
          errs++;
        end else begin
          exp_byte = exp_rx_q.pop_front();
          if (exp_byte != rx_data_i) begin
            $display("ERROR %0s: rx_data_o expected %h actual %h",
                     test_name_i, exp_byte, rx_data_i);
            errs++;
          end
        end
      end

      if (status_i.frame_err) begin
        ferr_cnt++;
      end
      if (status_i.overrun) begin
        ovr_cnt++;
      end
      if (tx_credit_i) begin
        credit_cnt++;
      end

      if (test_done_i) begin
        if (ferr_cnt != int'(exp_status_i.frame_err)) begin
          $display("ERROR %0s: frame_err pulses expected %0d actual %0d",
                   test_name_i, exp_status_i.frame_err, ferr_cnt);
          errs++;
        end
        if (ovr_cnt != int'(exp_status_i.overrun)) begin
          $display("ERROR %0s: overrun pulses expected %0d actual %0d",
                   test_name_i, exp_status_i.overrun, ovr_cnt);
          errs++;
        end
        if (credit_cnt != exp_credits) begin
          $display("ERROR %0s: tx_credit_o pulses expected %0d actual %0d",
                   test_name_i, exp_credits, credit_cnt);
          errs++;
        end
        if (exp_tx_q.size() != 0 || exp_rx_q.size() != 0) begin
          $display("test %0s: %0d transmit and %0d receive bytes never arrived",
                   test_name_i, exp_tx_q.size(), exp_rx_q.size());
          errs++;
          exp_tx_q.delete();
          exp_rx_q.delete();
        end
        if (errs == 0) begin
          $display("test %0s: ok", test_name_i);
          passed_o++;
        end else begin
          $display("test %0s: failed with %0d errors", test_name_i, errs);
          failed_o++;
        end
        errs        = 0;
        ferr_cnt    = 0;
        ovr_cnt     = 0;
        credit_cnt  = 0;
        exp_credits = 0;
      end

      idle_o = (exp_tx_q.size() == 0) && (exp_rx_q.size() == 0) && (tx_cnt < 0);
    end
  end

endmodule

// File: tb_uart_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench top with clock, reset, test table,
// serial line driver and loopback LFSR
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "uart_consts.svh"

module tb_uart_core import uart_pkg::*; ();

  localparam int N           = `UART_CYCLES_PER_SYMBOL;
  localparam int HostCredits = `UART_TX_CREDITS;
  localparam int NumTests    = 10;
  localparam int CreditLimit = 20 * N;
  localparam int IdleLimit   = 40 * N;

  typedef enum logic [2:0] {
    K_TX,
    K_RX,
    K_BURST,
    K_BADSTOP,
    K_GLITCH,
    K_LOOP
  } kind_e;

  typedef struct packed {
    logic [63:0]  name;
    uart_byte_t   data;
    kind_e        kind;
    uart_status_t status;
  } test_t;

  localparam uart_status_t StNone = '{frame_err: 1'b0, overrun: 1'b0};
  localparam uart_status_t StFerr = '{frame_err: 1'b1, overrun: 1'b0};
  localparam uart_status_t StOvr  = '{frame_err: 1'b0, overrun: 1'b1};

  logic         clk;
  logic         rst_n;
  uart_byte_t   tx_data;
  logic         tx_valid;
  logic         tx_credit;
  logic         dut_tx;
  logic         dut_rx;
  logic         rx_line;
  logic         loop_en;
  uart_byte_t   rx_data;
  logic         rx_valid;
  logic         rx_credit;
  uart_status_t status;

  // Checker controls
  logic [63:0]  cur_name;
  logic         exp_tx_push;
  uart_byte_t   exp_tx_byte;
  logic         exp_rx_push;
  uart_byte_t   exp_rx_byte;
  logic         test_done;
  uart_status_t exp_status;
  logic         chk_idle;
  int           passed;
  int           failed;

  test_t        tests [NumTests];
  logic [31:0]  lfsr = 32'hb717_b4fb;
  int           credits_back = 0;
  int           bytes_sent = 0;
  int           timeouts = 0;
  int           table_errs = 0;

  // Loopback ties the serial output straight back to the receiver
  assign dut_rx = loop_en ? dut_tx : rx_line;

  uart_core #(
    .cycles_per_symbol(N)
  ) DUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .tx_data_i  (tx_data),
    .tx_valid_i (tx_valid),
    .tx_credit_o(tx_credit),
    .tx_o       (dut_tx),
    .rx_i       (dut_rx),
    .rx_data_o  (rx_data),
    .rx_valid_o (rx_valid),
    .rx_credit_i(rx_credit),
    .status_o   (status)
  );

  tb_uart_checker #(
    .cycles_per_symbol(N)
  ) u_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .tx_i         (dut_tx),
    .tx_credit_i  (tx_credit),
    .rx_data_i    (rx_data),
    .rx_valid_i   (rx_valid),
    .status_i     (status),
    .test_name_i  (cur_name),
    .exp_tx_push_i(exp_tx_push),
    .exp_tx_byte_i(exp_tx_byte),
    .exp_rx_push_i(exp_rx_push),
    .exp_rx_byte_i(exp_rx_byte),
    .test_done_i  (test_done),
    .exp_status_i (exp_status),
    .idle_o       (chk_idle),
    .passed_o     (passed),
    .failed_o     (failed)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Host side count of credits returned by tx_credit pulses
  always @(negedge clk) begin
    if (rst_n && tx_credit) begin
      credits_back++;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic expect_tx(input uart_byte_t b);
    @(posedge clk);
    exp_tx_byte = b;
    exp_tx_push = 1'b1;
    @(posedge clk);
    exp_tx_push = 1'b0;
  endtask

  task automatic expect_rx(input uart_byte_t b);
    @(posedge clk);
    exp_rx_byte = b;
    exp_rx_push = 1'b1;
    @(posedge clk);
    exp_rx_push = 1'b0;
  endtask

  task automatic finish_test(input uart_status_t st);
    @(posedge clk);
    exp_status = st;
    test_done  = 1'b1;
    @(posedge clk);
    test_done  = 1'b0;
  endtask

  // Spends one credit, so it waits until the host holds one
  task automatic host_send(input uart_byte_t b);
    int t;
    t = 0;
    @(posedge clk);
    while (HostCredits + credits_back - bytes_sent <= 0 && t < CreditLimit) begin
      @(posedge clk);
      t++;
    end
    if (HostCredits + credits_back - bytes_sent <= 0) begin
      $display("timeout in test %0s: no transmit credit came back", cur_name);
      timeouts++;
    end else begin
      @(negedge clk);
      tx_data  = b;
      tx_valid = 1'b1;
      @(negedge clk);
      tx_valid = 1'b0;
      bytes_sent++;
    end
  endtask

  task automatic give_credits(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      @(negedge clk);
      rx_credit = 1'b1;
      @(negedge clk);
      rx_credit = 1'b0;
    end
  endtask

  // 8N1 frame on rx_line with N cycles per symbol
  task automatic send_frame(input uart_byte_t b, input logic stop);
    int k;
    @(negedge clk);
    rx_line = 1'b0;
    repeat (N) @(negedge clk);
    for (k = 0; k < 8; k++) begin
      rx_line = b[k];
      repeat (N) @(negedge clk);
    end
    rx_line = stop;
    repeat (N) @(negedge clk);
    // Idle symbol so the next start bit gives a falling edge
    rx_line = 1'b1;
    repeat (N) @(negedge clk);
  endtask

  // Low pulse shorter than half a symbol
  task automatic send_glitch();
    @(negedge clk);
    rx_line = 1'b0;
    repeat (N / 4) @(negedge clk);
    rx_line = 1'b1;
    repeat (2 * N) @(negedge clk);
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    @(posedge clk);
    while (!chk_idle && t < IdleLimit) begin
      @(posedge clk);
      t++;
    end
    if (!chk_idle) begin
      $display("timeout in test %0s: expected output never showed up", cur_name);
      timeouts++;
    end
  endtask

  initial begin : stimulus
    uart_byte_t d;
    int         i;
    int         j;
    rst_n       = 1'b0;
    tx_data     = '0;
    tx_valid    = 1'b0;
    rx_line     = 1'b1;
    rx_credit   = 1'b0;
    loop_en     = 1'b0;
    cur_name    = "reset___";
    exp_tx_push = 1'b0;
    exp_tx_byte = '0;
    exp_rx_push = 1'b0;
    exp_rx_byte = '0;
    test_done   = 1'b0;
    exp_status  = StNone;

    tests[0] = '{"tx_pair1", 8'ha5, K_TX, StNone};
    tests[1] = '{"tx_pair2", 8'h0f, K_TX, StNone};
    tests[2] = '{"rx_byte1", 8'h5a, K_RX, StNone};
    tests[3] = '{"rx_byte2", 8'h81, K_RX, StNone};
    tests[4] = '{"rx_burst", 8'h10, K_BURST, StOvr};
    tests[5] = '{"badstop1", 8'he7, K_BADSTOP, StFerr};
    tests[6] = '{"glitch_1", 8'hc3, K_GLITCH, StNone};
    tests[7] = '{"loopbk_1", 8'h00, K_LOOP, StNone};
    tests[8] = '{"loopbk_2", 8'h00, K_LOOP, StNone};
    tests[9] = '{"loopbk_3", 8'h00, K_LOOP, StNone};

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (i = 0; i < NumTests; i++) begin
      @(posedge clk);
      cur_name = tests[i].name;
      d = tests[i].data;
      case (tests[i].kind)
        K_TX: begin
          // Second byte waits in the pending slot while the first shifts
          expect_tx(d);
          expect_tx(~d);
          host_send(d);
          host_send(~d);
        end
        K_RX: begin
          expect_rx(d);
          give_credits(1);
          send_frame(d, 1'b1);
        end
        K_BURST: begin
          for (j = 0; j < 4; j++) begin
            expect_rx(d + uart_byte_t'(j));
          end
          // Fifth byte finds the buffer full
          for (j = 0; j < 5; j++) begin
            send_frame(d + uart_byte_t'(j), 1'b1);
          end
          give_credits(4);
        end
        K_BADSTOP: begin
          expect_rx(~d);
          give_credits(1);
          send_frame(d, 1'b0);
          send_frame(~d, 1'b1);
        end
        K_GLITCH: begin
          expect_rx(d);
          give_credits(1);
          send_glitch();
          send_frame(d, 1'b1);
        end
        K_LOOP: begin
          for (j = 0; j < 8; j++) begin
            lfsr = lfsr_step(lfsr);
            d = {d[6:0], lfsr[0]};
          end
          expect_tx(d);
          expect_rx(d);
          give_credits(1);
          @(negedge clk);
          loop_en = 1'b1;
          host_send(d);
        end
        default: begin
          $display("test %0s: unknown test kind", cur_name);
          table_errs++;
        end
      endcase
      wait_idle();
      @(negedge clk);
      loop_en = 1'b0;
      finish_test(tests[i].status);
    end

    @(posedge clk);
    @(posedge clk);
    $display("tests passed %0d, failed %0d, timeouts %0d", passed, failed, timeouts);
    if (failed == 0 && timeouts == 0 && table_errs == 0 && passed == NumTests) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: uart_core.f
+incdir+.
uart_pkg.sv
uart_baud_timer.sv
uart_tx.sv
uart_rx.sv
uart_rx_buffer.sv
uart_core.sv
tb_uart_checker.sv
tb_uart_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and check the result

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

verilator --binary --assert -j 0 --top-module tb_uart_core -f uart_core.f -o sim_uart
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_uart)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
